// File: design/lcd_defines.svh
/*
 * screen geometry and motion constants for a 480x272 RGB565 panel
 * track bounds are block origins, so a block's far edge is bound + block size - 1
 */
`ifndef LCD_DEFINES_SVH
`define LCD_DEFINES_SVH

// ------------------------------
// active area
`define LCD_H_ACTIVE       (480)
`define LCD_V_ACTIVE       (272)

// ------------------------------
// bar and band geometry
`define LCD_VBAR_W         (60)    // eight vertical bars
`define LCD_HBAR_H         (34)    // eight horizontal bars
`define LCD_BAND_H         (91)    // last band is one row short

// ------------------------------
// moving blocks
`define LCD_BLOCK_SIZE     (32)
`define LCD_TRACK_RIGHT    (448)   // outer track, origin x limit
`define LCD_TRACK_BOTTOM   (240)   // outer track, origin y limit
`define LCD_TRACK_INSET    (32)    // each inner track shrinks by this on all sides

// cycles between position steps
`define LCD_MOVE_PERIOD    (12288)

`endif

// File: design/lcd_pkg.sv
/*
 * shared types and the eight entry bar palette
 * mode values above PAT_BLOCKS are legal on the bus and render black
 */
package lcd_pkg;

	typedef logic [15:0] rgb565_t;    // 5|6|5
	typedef logic [8:0]  coord_t;
	typedef logic [3:0]  bar_idx_t;
	typedef logic [1:0]  band_t;      // 0 red, 1 green, 2 blue, 3 outside

	typedef enum logic [2:0]
	{
		PAT_VBARS    = 3'd0,
		PAT_HBARS    = 3'd1,
		PAT_GRID     = 3'd2,
		PAT_GRADIENT = 3'd3,
		PAT_BLOCKS   = 3'd4
	} pattern_mode_t;

	// clockwise walk around a track
	typedef enum logic [1:0]
	{
		DIR_RIGHT = 2'd0,
		DIR_DOWN  = 2'd1,
		DIR_LEFT  = 2'd2,
		DIR_UP    = 2'd3
	} move_dir_t;

	// ------------------------------
	// palette, listed in bar order
	localparam rgb565_t COL_RED     = 16'hF800;
	localparam rgb565_t COL_GREEN   = 16'h07E0;
	localparam rgb565_t COL_BLUE    = 16'h001F;
	localparam rgb565_t COL_WHITE   = 16'hFFFF;
	localparam rgb565_t COL_BLACK   = 16'h0000;
	localparam rgb565_t COL_YELLOW  = 16'hFFE0;
	localparam rgb565_t COL_MAGENTA = 16'hF81F;
	localparam rgb565_t COL_CYAN    = 16'h07FF;

endpackage

// File: design/block_mover.sv
/*
 * three 32x32 blocks on nested clockwise tracks with block k inset by 32*k
 * one pixel step per tick; a corner costs one tick to turn without moving
 * MOVE_PERIOD of 1 gives a tick every cycle
 */
`include "lcd_defines.svh"

module block_mover
#(
	parameter int MOVE_PERIOD = `LCD_MOVE_PERIOD
)
(
	input  logic            clk,
	input  logic            rst_n,
	output lcd_pkg::coord_t red_x,
	output lcd_pkg::coord_t red_y,
	output lcd_pkg::coord_t green_x,
	output lcd_pkg::coord_t green_y,
	output lcd_pkg::coord_t blue_x,
	output lcd_pkg::coord_t blue_y
);

	import lcd_pkg::*;

	localparam int NUM_BLK = 3;
	localparam int CNT_W   = (MOVE_PERIOD > 1) ? $clog2(MOVE_PERIOD) : 1;

	// per block track limits
	function automatic coord_t trk_lo(int k);
		return coord_t'(k * `LCD_TRACK_INSET);
	endfunction

	function automatic coord_t trk_right(int k);
		return coord_t'(`LCD_TRACK_RIGHT - k * `LCD_TRACK_INSET);
	endfunction

	function automatic coord_t trk_bottom(int k);
		return coord_t'(`LCD_TRACK_BOTTOM - k * `LCD_TRACK_INSET);
	endfunction

	logic [CNT_W-1:0] tick_cnt;
	logic             move_tick;
	coord_t           blk_x [NUM_BLK];
	coord_t           blk_y [NUM_BLK];
	move_dir_t        blk_dir [NUM_BLK];

	// ------------------------------
	// move tick
	assign move_tick = (tick_cnt == CNT_W'(MOVE_PERIOD - 1));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tick_cnt <= '0;
		else if (move_tick)
			tick_cnt <= '0;    // wrap
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	// ------------------------------
	// one motion FSM per block
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int k = 0; k < NUM_BLK; k++)
			begin
				blk_x[k]   <= trk_lo(k);
				blk_y[k]   <= trk_lo(k);
				blk_dir[k] <= DIR_RIGHT;
			end
		end
		else if (move_tick)
		begin
			for (int k = 0; k < NUM_BLK; k++)
			begin
				case (blk_dir[k])
					DIR_RIGHT:
						if (blk_x[k] < trk_right(k))
							blk_x[k] <= blk_x[k] + 1'b1;
						else
							blk_dir[k] <= DIR_DOWN;
					DIR_DOWN:
						if (blk_y[k] < trk_bottom(k))
							blk_y[k] <= blk_y[k] + 1'b1;
						else
							blk_dir[k] <= DIR_LEFT;
					DIR_LEFT:
						if (blk_x[k] > trk_lo(k))
							blk_x[k] <= blk_x[k] - 1'b1;
						else
							blk_dir[k] <= DIR_UP;
					DIR_UP:
						if (blk_y[k] > trk_lo(k))
							blk_y[k] <= blk_y[k] - 1'b1;
						else
							blk_dir[k] <= DIR_RIGHT;    // lap done
				endcase
			end
		end
	end

	assign red_x   = blk_x[0];
	assign red_y   = blk_y[0];
	assign green_x = blk_x[1];
	assign green_y = blk_y[1];
	assign blue_x  = blk_x[2];
	assign blue_y  = blk_y[2];

	for (genvar k = 0; k < NUM_BLK; k++)
	begin : g_chk
		a_in_track: assert property (@(posedge clk) disable iff (!rst_n)
			blk_x[k] >= trk_lo(k) && blk_x[k] <= trk_right(k) &&
			blk_y[k] >= trk_lo(k) && blk_y[k] <= trk_bottom(k));
	end

endmodule

// File: design/pixel_decode.sv
/*
 * first pipeline stage, one cycle from coordinate to decoded fields
 * bar and band come from range compares, so pixel order does not matter
 * block origins are used as held before the sampling edge
 */
`include "lcd_defines.svh"

module pixel_decode
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  pixel_valid,
	input  lcd_pkg::coord_t       x_pos,
	input  lcd_pkg::coord_t       y_pos,
	input  lcd_pkg::pattern_mode_t mode,
	input  lcd_pkg::coord_t       red_x,
	input  lcd_pkg::coord_t       red_y,
	input  lcd_pkg::coord_t       green_x,
	input  lcd_pkg::coord_t       green_y,
	input  lcd_pkg::coord_t       blue_x,
	input  lcd_pkg::coord_t       blue_y,
	output logic                  dec_valid,
	output lcd_pkg::pattern_mode_t dec_mode,
	output logic                  dec_in_frame,
	output lcd_pkg::bar_idx_t     vbar_idx,
	output lcd_pkg::bar_idx_t     hbar_idx,
	output lcd_pkg::band_t        band,
	output logic [5:0]            grad_level,
	output logic [2:0]            block_hit
);

	import lcd_pkg::*;

	// highest bar whose left/top edge the position has passed
	function automatic bar_idx_t bar_of(coord_t pos, int unsigned pitch);
		bar_idx_t idx;
		idx = '0;
		for (int unsigned i = 1; i < 16; i++)
			if (32'(pos) >= i * pitch)
				idx = bar_idx_t'(i);
		return idx;
	endfunction

	// origin .. origin+size-1 on one axis
	function automatic logic in_span(coord_t pos, coord_t org);
		return (pos >= org) && (coord_t'(pos - org) < coord_t'(`LCD_BLOCK_SIZE));
	endfunction

	logic     in_frame_c;
	bar_idx_t vbar_c;
	bar_idx_t hbar_c;
	band_t    band_c;
	logic [2:0] hit_c;

	// ------------------------------
	// combinational decode
	always_comb
	begin
		in_frame_c = (x_pos < coord_t'(`LCD_H_ACTIVE)) && (y_pos < coord_t'(`LCD_V_ACTIVE));
		vbar_c = bar_of(x_pos, `LCD_VBAR_W);
		hbar_c = bar_of(y_pos, `LCD_HBAR_H);

		if (y_pos < coord_t'(`LCD_BAND_H))
			band_c = 2'd0;
		else if (y_pos < coord_t'(2 * `LCD_BAND_H))
			band_c = 2'd1;
		else if (y_pos < coord_t'(`LCD_V_ACTIVE))
			band_c = 2'd2;
		else
			band_c = 2'd3;    // below the last band

		hit_c[0] = in_span(x_pos, red_x) && in_span(y_pos, red_y);
		hit_c[1] = in_span(x_pos, green_x) && in_span(y_pos, green_y);
		hit_c[2] = in_span(x_pos, blue_x) && in_span(y_pos, blue_y);
	end

	// ------------------------------
	// stage register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			dec_valid <= 1'b0;
		else
			dec_valid <= pixel_valid;
	end

	always_ff @(posedge clk)
	begin
		dec_mode     <= mode;
		dec_in_frame <= in_frame_c;
		vbar_idx     <= vbar_c;
		hbar_idx     <= hbar_c;
		band         <= band_c;
		grad_level   <= x_pos[8:3];    // red/blue drop the lsb later
		block_hit    <= hit_c;
	end

	a_mode_known: assert property (@(posedge clk) disable iff (!rst_n)
		pixel_valid |-> !$isunknown(mode));

endmodule

// File: design/color_result.sv
/*
 * second pipeline stage, picks the colour by mode and registers it
 * invalid or out-of-frame pixels come out black
 * block priority is fixed red, green, blue
 */
module color_result
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   dec_valid,
	input  lcd_pkg::pattern_mode_t dec_mode,
	input  logic                   dec_in_frame,
	input  lcd_pkg::bar_idx_t      vbar_idx,
	input  lcd_pkg::bar_idx_t      hbar_idx,
	input  lcd_pkg::band_t         band,
	input  logic [5:0]             grad_level,
	input  logic [2:0]             block_hit,
	output logic                   lcd_valid,
	output lcd_pkg::rgb565_t       lcd_data
);

	import lcd_pkg::*;

	function automatic rgb565_t palette(bar_idx_t idx);
		case (idx)
			4'd0:    return COL_RED;
			4'd1:    return COL_GREEN;
			4'd2:    return COL_BLUE;
			4'd3:    return COL_WHITE;
			4'd4:    return COL_BLACK;
			4'd5:    return COL_YELLOW;
			4'd6:    return COL_MAGENTA;
			4'd7:    return COL_CYAN;
			default: return COL_BLACK;    // only reached off screen
		endcase
	endfunction

	rgb565_t vbar_col;
	rgb565_t hbar_col;
	rgb565_t pix_col;

	assign vbar_col = palette(vbar_idx);
	assign hbar_col = palette(hbar_idx);

	// ------------------------------
	// colour rule by mode
	always_comb
	begin
		case (dec_mode)
			PAT_VBARS:    pix_col = vbar_col;
			PAT_HBARS:    pix_col = hbar_col;
			PAT_GRID:     pix_col = vbar_col ^ hbar_col;
			PAT_GRADIENT:
				case (band)
					2'd0:    pix_col = {grad_level[5:1], 11'b0};
					2'd1:    pix_col = {5'b0, grad_level, 5'b0};
					2'd2:    pix_col = {11'b0, grad_level[5:1]};
					default: pix_col = COL_BLACK;
				endcase
			PAT_BLOCKS:
				if (block_hit[0])
					pix_col = COL_RED;
				else if (block_hit[1])
					pix_col = COL_GREEN;
				else if (block_hit[2])
					pix_col = COL_BLUE;
				else
					pix_col = COL_BLACK;
			default:      pix_col = COL_BLACK;    // unused mode codes
		endcase
	end

	// ------------------------------
	// output register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			lcd_valid <= 1'b0;
			lcd_data  <= COL_BLACK;
		end
		else
		begin
			lcd_valid <= dec_valid;
			lcd_data  <= (dec_valid && dec_in_frame) ? pix_col : COL_BLACK;
		end
	end

	a_idle_black: assert property (@(posedge clk)
		!lcd_valid |-> lcd_data == COL_BLACK);

endmodule

// File: design/lcd_pattern_top.sv
/*
 * pattern generator, two cycles from coordinate in to colour out
 * pixel_valid is a single-cycle strobe; there is no back-pressure
 */
`include "lcd_defines.svh"

module lcd_pattern_top
#(
	parameter int MOVE_PERIOD = `LCD_MOVE_PERIOD
)
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   pixel_valid,
	input  lcd_pkg::coord_t        x_pos,
	input  lcd_pkg::coord_t        y_pos,
	input  lcd_pkg::pattern_mode_t mode,
	output logic                   lcd_valid,
	output lcd_pkg::rgb565_t       lcd_data
);

	import lcd_pkg::*;

	// block origins
	coord_t red_x, red_y;
	coord_t green_x, green_y;
	coord_t blue_x, blue_y;

	// decode to result
	logic          dec_valid;
	pattern_mode_t dec_mode;
	logic          dec_in_frame;
	bar_idx_t      vbar_idx;
	bar_idx_t      hbar_idx;
	band_t         band;
	logic [5:0]    grad_level;
	logic [2:0]    block_hit;

	block_mover #(.MOVE_PERIOD(MOVE_PERIOD)) u_mover
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.red_x   (red_x),
		.red_y   (red_y),
		.green_x (green_x),
		.green_y (green_y),
		.blue_x  (blue_x),
		.blue_y  (blue_y)
	);

	pixel_decode u_decode
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.pixel_valid  (pixel_valid),
		.x_pos        (x_pos),
		.y_pos        (y_pos),
		.mode         (mode),
		.red_x        (red_x),
		.red_y        (red_y),
		.green_x      (green_x),
		.green_y      (green_y),
		.blue_x       (blue_x),
		.blue_y       (blue_y),
		.dec_valid    (dec_valid),
		.dec_mode     (dec_mode),
		.dec_in_frame (dec_in_frame),
		.vbar_idx     (vbar_idx),
		.hbar_idx     (hbar_idx),
		.band         (band),
		.grad_level   (grad_level),
		.block_hit    (block_hit)
	);

	color_result u_result
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.dec_valid    (dec_valid),
		.dec_mode     (dec_mode),
		.dec_in_frame (dec_in_frame),
		.vbar_idx     (vbar_idx),
		.hbar_idx     (hbar_idx),
		.band         (band),
		.grad_level   (grad_level),
		.block_hit    (block_hit),
		.lcd_valid    (lcd_valid),
		.lcd_data     (lcd_data)
	);

endmodule

// File: bench/lcd_checker.sv
/*
 * reference model of the five patterns and the block motion
 * inputs sampled at an edge show on the outputs after the next edge
 * compares on the falling edge, when the DUT outputs are settled
 */
`include "lcd_defines.svh"

module lcd_checker
#(
	parameter int MOVE_PERIOD = `LCD_MOVE_PERIOD
)
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   pixel_valid,
	input  lcd_pkg::coord_t        x_pos,
	input  lcd_pkg::coord_t        y_pos,
	input  lcd_pkg::pattern_mode_t mode,
	input  logic                   lcd_valid,
	input  lcd_pkg::rgb565_t       lcd_data,
	input  logic                   report,
	output int                     error_count
);

	timeunit 1ns;
	timeprecision 1ps;

	import lcd_pkg::*;

	localparam rgb565_t PALETTE [8] = '{COL_RED, COL_GREEN, COL_BLUE, COL_WHITE,
		COL_BLACK, COL_YELLOW, COL_MAGENTA, COL_CYAN};

	int        tick_cnt;
	int        blk_x [3];
	int        blk_y [3];
	move_dir_t blk_dir [3];

	// [0] sampled at the last edge, [1] now on the outputs
	logic       exp_valid [2];
	rgb565_t    exp_data [2];
	int         exp_x [2];
	int         exp_y [2];
	logic [2:0] exp_mode [2];

	int check_count  = 0;
	int pixel_count  = 0;
	int valid_errors = 0;
	int data_errors  = 0;

	function automatic logic covers(int k, int x, int y);
		return x >= blk_x[k] && x <= blk_x[k] + `LCD_BLOCK_SIZE - 1 &&
			y >= blk_y[k] && y <= blk_y[k] + `LCD_BLOCK_SIZE - 1;
	endfunction

	function automatic rgb565_t expected_color(int x, int y, pattern_mode_t m);
		coord_t  xv;
		rgb565_t col;
		xv  = coord_t'(x);
		col = COL_BLACK;
		if (x >= `LCD_H_ACTIVE || y >= `LCD_V_ACTIVE)
			return COL_BLACK;
		case (m)
			PAT_VBARS: col = PALETTE[3'(x / `LCD_VBAR_W)];
			PAT_HBARS: col = PALETTE[3'(y / `LCD_HBAR_H)];
			PAT_GRID:  col = PALETTE[3'(x / `LCD_VBAR_W)] ^ PALETTE[3'(y / `LCD_HBAR_H)];
			PAT_GRADIENT:
				if (y < `LCD_BAND_H)
					col = {xv[8:4], 11'b0};
				else if (y < 2 * `LCD_BAND_H)
					col = {5'b0, xv[8:3], 5'b0};
				else
					col = {11'b0, xv[8:4]};
			PAT_BLOCKS:
				if (covers(0, x, y))
					col = COL_RED;
				else if (covers(1, x, y))
					col = COL_GREEN;
				else if (covers(2, x, y))
					col = COL_BLUE;
			default: col = COL_BLACK;
		endcase
		return col;
	endfunction

	task automatic reset_model();
		tick_cnt = 0;
		for (int k = 0; k < 3; k++)
		begin
			blk_x[k]   = k * `LCD_TRACK_INSET;
			blk_y[k]   = k * `LCD_TRACK_INSET;
			blk_dir[k] = DIR_RIGHT;
		end
		for (int s = 0; s < 2; s++)
		begin
			exp_valid[s] = 1'b0;
			exp_data[s]  = COL_BLACK;
			exp_x[s]     = 0;
			exp_y[s]     = 0;
			exp_mode[s]  = '0;
		end
	endtask

	// one tick: move inside the limits, else turn in place
	task automatic step_blocks();
		int lo;
		int right;
		int bottom;
		for (int k = 0; k < 3; k++)
		begin
			lo     = k * `LCD_TRACK_INSET;
			right  = `LCD_TRACK_RIGHT - k * `LCD_TRACK_INSET;
			bottom = `LCD_TRACK_BOTTOM - k * `LCD_TRACK_INSET;
			case (blk_dir[k])
				DIR_RIGHT:
					if (blk_x[k] < right)
						blk_x[k] = blk_x[k] + 1;
					else
						blk_dir[k] = DIR_DOWN;
				DIR_DOWN:
					if (blk_y[k] < bottom)
						blk_y[k] = blk_y[k] + 1;
					else
						blk_dir[k] = DIR_LEFT;
				DIR_LEFT:
					if (blk_x[k] > lo)
						blk_x[k] = blk_x[k] - 1;
					else
						blk_dir[k] = DIR_UP;
				default:
					if (blk_y[k] > lo)
						blk_y[k] = blk_y[k] - 1;
					else
						blk_dir[k] = DIR_RIGHT;
			endcase
		end
	endtask

	// ------------------------------
	// model update at the sampling edge
	always @(posedge clk)
	begin
		if (!rst_n)
			reset_model();
		else
		begin
			exp_valid[1] = exp_valid[0];
			exp_data[1]  = exp_data[0];
			exp_x[1]     = exp_x[0];
			exp_y[1]     = exp_y[0];
			exp_mode[1]  = exp_mode[0];
			exp_valid[0] = pixel_valid;
			exp_x[0]     = int'(x_pos);
			exp_y[0]     = int'(y_pos);
			exp_mode[0]  = mode;
			// origins as held before this edge
			exp_data[0]  = pixel_valid ? expected_color(exp_x[0], exp_y[0], mode) : COL_BLACK;
			if (tick_cnt == MOVE_PERIOD - 1)
			begin
				step_blocks();
				tick_cnt = 0;
			end
			else
				tick_cnt = tick_cnt + 1;
		end
	end

	// ------------------------------
	// compare
	always @(negedge clk)
	begin
		check_count = check_count + 1;
		if (exp_valid[1])
			pixel_count = pixel_count + 1;
		if (lcd_valid !== exp_valid[1])
		begin
			valid_errors = valid_errors + 1;
			$display("CHECK FAILED lcd_valid: expected %h, got %h (x %h, y %h, mode %h)",
				exp_valid[1], lcd_valid, exp_x[1], exp_y[1], exp_mode[1]);
		end
		if (lcd_data !== exp_data[1])
		begin
			data_errors = data_errors + 1;
			$display("CHECK FAILED lcd_data: expected %h, got %h (x %h, y %h, mode %h)",
				exp_data[1], lcd_data, exp_x[1], exp_y[1], exp_mode[1]);
		end
	end

	assign error_count = valid_errors + data_errors;

	always @(posedge report)
		$display("lcd_checker: %0d cycles, %0d pixels, %0d errors (lcd_valid %0d, lcd_data %0d)",
			check_count, pixel_count, error_count, valid_errors, data_errors);

endmodule

// File: bench/tb_lcd_pattern.sv
/*
 * testbench for lcd_pattern_top with a short move period so blocks lap often
 * random pixels from a fixed seed; block mode aims most pixels at the blocks
 */
module tb_lcd_pattern;

	timeunit 1ns;
	timeprecision 1ps;

	import lcd_pkg::*;

	localparam int MOVE_PERIOD    = 4;
	localparam int RESET_CYCLES   = 16;
	localparam int STIM_CYCLES    = 20000;
	localparam int TIMEOUT_CYCLES = STIM_CYCLES * 11 / 10;    // 10% over the stimulus
	localparam int DRIVE_DELAY    = 10;

	logic          clk;
	logic          rst_n;
	logic          pixel_valid;
	coord_t        x_pos;
	coord_t        y_pos;
	pattern_mode_t mode;
	logic          lcd_valid;
	rgb565_t       lcd_data;
	logic          report;
	int            error_count;
	int            cycle_cnt = 0;

	lcd_pattern_top #(.MOVE_PERIOD(MOVE_PERIOD)) dut
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.pixel_valid (pixel_valid),
		.x_pos       (x_pos),
		.y_pos       (y_pos),
		.mode        (mode),
		.lcd_valid   (lcd_valid),
		.lcd_data    (lcd_data)
	);

	lcd_checker #(.MOVE_PERIOD(MOVE_PERIOD)) chk
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.pixel_valid (pixel_valid),
		.x_pos       (x_pos),
		.y_pos       (y_pos),
		.mode        (mode),
		.lcd_valid   (lcd_valid),
		.lcd_data    (lcd_data),
		.report      (report),
		.error_count (error_count)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// weighted toward blocks, unused codes 5..7 included
	function automatic pattern_mode_t pick_mode();
		int unsigned r;
		r = $urandom_range(0, 11);
		if (r < 5)
			return pattern_mode_t'(3'(r));
		else if (r < 9)
			return PAT_BLOCKS;
		return pattern_mode_t'(3'(r - 4));
	endfunction

	task automatic drive_pixel(pattern_mode_t cur_mode);
		int k;
		pixel_valid = ($urandom_range(0, 99) < 80);
		mode        = cur_mode;
		if (cur_mode == PAT_BLOCKS && $urandom_range(0, 9) < 6)
		begin
			k     = int'($urandom_range(0, 2));    // near a modelled origin, edges too
			x_pos = coord_t'(chk.blk_x[k] + int'($urandom_range(0, 39)) - 4);
			y_pos = coord_t'(chk.blk_y[k] + int'($urandom_range(0, 39)) - 4);
		end
		else
		begin
			x_pos = coord_t'($urandom_range(0, 511));
			y_pos = coord_t'($urandom_range(0, 511));
		end
	endtask

	// ------------------------------
	// stimulus
	initial
	begin
		pattern_mode_t cur_mode;
		int            run_left;
		void'($urandom(32'h3eac_eb83));
		rst_n       = 1'b0;
		pixel_valid = 1'b0;
		x_pos       = '0;
		y_pos       = '0;
		mode        = PAT_VBARS;
		report      = 1'b0;
		cur_mode    = PAT_VBARS;
		run_left    = 0;

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;

		for (int i = 0; i < STIM_CYCLES; i++)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
			if (run_left == 0)
			begin
				cur_mode = pick_mode();
				run_left = int'($urandom_range(20, 200));
			end
			run_left = run_left - 1;
			drive_pixel(cur_mode);
		end

		@(posedge clk);
		#DRIVE_DELAY;
		pixel_valid = 1'b0;
		repeat (3) @(posedge clk);    // drain both stages
		report = 1'b1;
		#1;
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// ------------------------------
	// watchdog
	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES)
		begin
			$display("timeout, run still going after %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

endmodule

// File: project.f
+incdir+design
design/lcd_pkg.sv
design/block_mover.sv
design/pixel_decode.sv
design/color_result.sv
design/lcd_pattern_top.sv
bench/lcd_checker.sv
bench/tb_lcd_pattern.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the lcd pattern testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f project.f --top-module tb_lcd_pattern -o sim_lcd_pattern \
	|| { echo "verilator build failed"; exit 1; }

sim_out=$(./obj_dir/sim_lcd_pattern)
echo "$sim_out"
echo "$sim_out" | grep -qx "Simulation passed" && exit 0 || exit 1
